/* src/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Width of data words, addresses and instructions
`define CPU_DATA_W 16

// Instruction memory depth in words
`define CPU_IMEM_DEPTH 256

// Data memory depth in words
`define CPU_DMEM_DEPTH 256

// Register count, r0 reads as zero
`define CPU_NREGS 16

`endif

/* src/cpuPkg.sv */
package cpuPkg;

	// Major opcode in the top nibble
	// Unlisted codes behave as NOP
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		XOR = 4'h2,
		AND = 4'h3,
		LW  = 4'h8,
		SW  = 4'h9,
		LLB = 4'hA,
		LHB = 4'hB,
		B   = 4'hC,
		NOP = 4'hE,
		HLT = 4'hF
	} opcodeT;

	// Branch condition codes, tested against N, V and Z
	typedef enum logic [2:0] {
		NE, EQ, GT, LT, GE, LE, OVF, ALWAYS
	} condT;

	// Low byte is either two register fields or one immediate
	typedef union packed {
		struct packed {
			opcodeT op;
			logic [3:0] rd;
			logic [3:0] rs;
			// Word offset for LW and SW
			logic [3:0] rt;
		} r;
		struct packed {
			opcodeT op;
			// Branch keeps the condition in rd[3:1]
			logic [3:0] rd;
			logic [7:0] imm8;
		} i;
	} instrT;

	// Writeback data source
	typedef enum logic [1:0] {
		ALU = 2'd0,
		MEM = 2'd1,
		IMM = 2'd2
	} wbSrcT;

endpackage

/* src/fetch.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module fetch import cpuPkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic imemWe,
	input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imemAddr,
	input  logic [`CPU_DATA_W-1:0] imemData,
	input  logic stall,
	input  logic halt,
	input  logic branchTaken,
	input  logic [`CPU_DATA_W-1:0] branchTarget,
	output logic [`CPU_DATA_W-1:0] pc,
	output instrT instrId,
	output logic [`CPU_DATA_W-1:0] pcId
);

	localparam int imemAw = $clog2(`CPU_IMEM_DEPTH);
	localparam instrT nopInstr = instrT'({NOP, 12'h000});

	logic [`CPU_DATA_W-1:0] imem [`CPU_IMEM_DEPTH];
	logic halted, frozen;

	// Program load port, driven while the core sits in reset
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	// HLT in decode stops fetch for good
	assign frozen = halt | halted;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			pcId <= '0;
			instrId <= nopInstr;
			halted <= 1'b0;
		end else begin
			halted <= frozen;
			if (branchTaken) begin
				// Squash the fall-through word, no delay slot
				pc <= branchTarget;
				instrId <= nopInstr;
			end else if (frozen) begin
				instrId <= nopInstr;
			end else if (!stall) begin
				pc <= pc + 1'b1;
				pcId <= pc;
				instrId <= instrT'(imem[pc[imemAw-1:0]]);
			end
		end
	end

	// Branch resolution in decode waits out its own hazards
	stallBranchExcl: assert property (@(posedge clk) disable iff (rst)
		!(stall && branchTaken));

endmodule

/* src/decode.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module decode import cpuPkg::*; (
	input  logic clk,
	input  logic rst,
	input  instrT instrId,
	input  logic [`CPU_DATA_W-1:0] pcId,
	// N, V, Z from the execute flag register
	input  logic [2:0] flags,
	input  logic wbRegWr,
	input  logic [$clog2(`CPU_NREGS)-1:0] wbRd,
	input  logic [`CPU_DATA_W-1:0] wbData,
	output logic stall,
	output logic halt,
	output logic branchTaken,
	output logic [`CPU_DATA_W-1:0] branchTarget,
	output opcodeT exOp,
	output logic [$clog2(`CPU_NREGS)-1:0] exRd,
	output logic [$clog2(`CPU_NREGS)-1:0] exRs,
	output logic [$clog2(`CPU_NREGS)-1:0] exRt,
	output logic [`CPU_DATA_W-1:0] exData1,
	output logic [`CPU_DATA_W-1:0] exData2,
	output logic [`CPU_DATA_W-1:0] exImm,
	output logic exAluSrc,
	output logic exMemRd,
	output logic exMemWr,
	output logic exRegWr,
	output wbSrcT exWbSrc,
	output logic exHalt
);

	localparam int regAw = $clog2(`CPU_NREGS);

	logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];
	logic [`CPU_DATA_W-1:0] dataA, dataB, imm;
	logic [regAw-1:0] readA, readB;
	logic aluSrc, memRd, memWr, regWr, isBranch, condTrue;
	logic loadUse, flagHazard;
	opcodeT op;
	wbSrcT wbSrc;

	// Register read with writeback bypass
	function automatic logic [`CPU_DATA_W-1:0] readReg(input logic [regAw-1:0] idx);
		if (idx == '0) begin
			return '0;
		end else if (wbRegWr && wbRd == idx) begin
			return wbData;
		end
		return regs[idx];
	endfunction

	assign op = instrId.r.op;

	// Controls and source register selection per opcode
	always_comb begin
		readA = '0;
		readB = '0;
		aluSrc = 1'b0;
		memRd = 1'b0;
		memWr = 1'b0;
		regWr = 1'b0;
		wbSrc = ALU;
		isBranch = 1'b0;
		halt = 1'b0;
		case (op)
			ADD, SUB, AND, XOR: begin
				readA = instrId.r.rs;
				readB = instrId.r.rt;
				regWr = 1'b1;
			end
			LW: begin
				readA = instrId.r.rs;
				aluSrc = 1'b1;
				memRd = 1'b1;
				regWr = 1'b1;
				wbSrc = MEM;
			end
			SW: begin
				readA = instrId.r.rs;
				// Store data sits in the rd field
				readB = instrId.r.rd;
				aluSrc = 1'b1;
				memWr = 1'b1;
			end
			LLB, LHB: begin
				// Old value of rd supplies the kept byte
				readA = instrId.i.rd;
				regWr = 1'b1;
				wbSrc = IMM;
			end
			B: isBranch = 1'b1;
			HLT: halt = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		dataA = readReg(readA);
		dataB = readReg(readB);
	end

	// Immediate forms
	always_comb begin
		case (op)
			LLB: imm = {dataA[`CPU_DATA_W-1:8], instrId.i.imm8};
			LHB: imm = {instrId.i.imm8, dataA[7:0]};
			default: imm = {{(`CPU_DATA_W-4){1'b0}}, instrId.r.rt};
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < `CPU_NREGS; k++) begin
				regs[k] <= '0;
			end
		end else if (wbRegWr && wbRd != '0) begin
			regs[wbRd] <= wbData;
		end
	end

	// Load data only exists in writeback
	assign loadUse = (exOp == LW) && (exRd != '0) && (exRd == readA || exRd == readB);
	// Branch waits until the ALU op ahead has written the flags
	assign flagHazard = isBranch && (exOp inside {ADD, SUB, AND, XOR});
	assign stall = loadUse | flagHazard;

	// flags[2] N, flags[1] V, flags[0] Z
	always_comb begin
		case (condT'(instrId.i.rd[3:1]))
			NE: condTrue = !flags[0];
			EQ: condTrue = flags[0];
			GT: condTrue = !flags[0] && !flags[2];
			LT: condTrue = flags[2];
			GE: condTrue = flags[0] || !flags[2];
			LE: condTrue = flags[2] || flags[0];
			OVF: condTrue = flags[1];
			default: condTrue = 1'b1;
		endcase
	end

	// B reads no register, so the flag hazard is its only wait
	assign branchTaken = isBranch && condTrue && !flagHazard;
	// 9-bit signed word offset from rd[0] and imm8
	assign branchTarget = pcId + 1'b1 +
		{{(`CPU_DATA_W-8){instrId.i.rd[0]}}, instrId.i.imm8};

	// ID/EX control, bubble on stall
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			exOp <= NOP;
			exRs <= '0;
			exRt <= '0;
			exMemRd <= 1'b0;
			exMemWr <= 1'b0;
			exRegWr <= 1'b0;
			exHalt <= 1'b0;
		end else begin
			exOp <= op;
			exRs <= readA;
			exRt <= readB;
			exMemRd <= memRd;
			exMemWr <= memWr;
			exRegWr <= regWr;
			exHalt <= halt;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		exRd <= instrId.r.rd;
		exData1 <= dataA;
		exData2 <= dataB;
		exImm <= imm;
		exAluSrc <= aluSrc;
		exWbSrc <= wbSrc;
	end

	// Bubbles and NOP words leave no side effect behind them
	bubbleNoWrite: assert property (@(posedge clk) disable iff (rst)
		(exOp == NOP) |-> !exRegWr && !exMemWr);

endmodule

/* src/execute.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module execute import cpuPkg::*; (
	input  logic clk,
	input  logic rst,
	input  opcodeT exOp,
	input  logic [$clog2(`CPU_NREGS)-1:0] exRd,
	input  logic [$clog2(`CPU_NREGS)-1:0] exRs,
	input  logic [$clog2(`CPU_NREGS)-1:0] exRt,
	input  logic [`CPU_DATA_W-1:0] exData1,
	input  logic [`CPU_DATA_W-1:0] exData2,
	input  logic [`CPU_DATA_W-1:0] exImm,
	input  logic exAluSrc,
	input  logic exMemRd,
	input  logic exMemWr,
	input  logic exRegWr,
	input  wbSrcT exWbSrc,
	input  logic exHalt,
	input  logic [$clog2(`CPU_NREGS)-1:0] wbRd,
	input  logic wbRegWr,
	input  logic [`CPU_DATA_W-1:0] wbData,
	output logic [2:0] flags,
	output logic [`CPU_DATA_W-1:0] memAluOut,
	output logic [`CPU_DATA_W-1:0] memStoreData,
	output logic [$clog2(`CPU_NREGS)-1:0] memRd,
	output logic memRegWr,
	output logic memMemRd,
	output logic memMemWr,
	output wbSrcT memWbSrc,
	output logic [`CPU_DATA_W-1:0] memImm,
	output logic memHalt
);

	localparam int msb = `CPU_DATA_W - 1;

	logic [`CPU_DATA_W-1:0] opA, opB, aluB, result, merged, memFwd;
	logic fwdAMem, fwdBMem, fwdAWb, fwdBWb, ovf;

	// Youngest producer wins, r0 never forwards
	assign fwdAMem = memRegWr && memRd != '0 && memRd == exRs;
	assign fwdBMem = memRegWr && memRd != '0 && memRd == exRt;
	assign fwdAWb = wbRegWr && wbRd != '0 && wbRd == exRs;
	assign fwdBWb = wbRegWr && wbRd != '0 && wbRd == exRt;

	// Byte loads carry their value in memImm, the rest in memAluOut
	assign memFwd = (memWbSrc == IMM) ? memImm : memAluOut;

	assign opA = fwdAMem ? memFwd : (fwdAWb ? wbData : exData1);
	assign opB = fwdBMem ? memFwd : (fwdBWb ? wbData : exData2);
	assign aluB = exAluSrc ? exImm : opB;

	// Byte insert against the forwarded rd value
	assign merged = (exOp == LHB) ? {exImm[msb:8], opA[7:0]} : {opA[msb:8], exImm[7:0]};

	always_comb begin
		ovf = 1'b0;
		case (exOp)
			SUB: begin
				result = opA - aluB;
				ovf = (opA[msb] != aluB[msb]) && (result[msb] != opA[msb]);
			end
			AND: result = opA & aluB;
			XOR: result = opA ^ aluB;
			default: begin
				// ADD, also base plus offset for LW and SW
				result = opA + aluB;
				ovf = (opA[msb] == aluB[msb]) && (result[msb] != opA[msb]);
			end
		endcase
	end

	// Flags and EX/MEM control
	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
			memRegWr <= 1'b0;
			memMemRd <= 1'b0;
			memMemWr <= 1'b0;
			memHalt <= 1'b0;
		end else begin
			// Only the four ALU ops touch NVZ
			if (exOp inside {ADD, SUB, AND, XOR}) begin
				flags <= {result[msb], ovf, result == '0};
			end
			memRegWr <= exRegWr;
			memMemRd <= exMemRd;
			memMemWr <= exMemWr;
			memHalt <= exHalt;
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		memAluOut <= result;
		memStoreData <= opB;
		memRd <= exRd;
		memWbSrc <= exWbSrc;
		memImm <= merged;
	end

	// Load-use stall keeps a pending load off the MEM forward path
	fwdNoLoad: assert property (@(posedge clk) disable iff (rst)
		(fwdAMem || fwdBMem) |-> !memMemRd);

	// r0 operands reach the ALU as zero whatever sits downstream
	fwdNoR0: assert property (@(posedge clk) disable iff (rst)
		(exRegWr || exMemWr) |-> (exRs != '0 || opA == '0) && (exRt != '0 || opB == '0));

endmodule

/* src/memory.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module memory import cpuPkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic [`CPU_DATA_W-1:0] memAluOut,
	input  logic [`CPU_DATA_W-1:0] memStoreData,
	input  logic [$clog2(`CPU_NREGS)-1:0] memRd,
	input  logic memRegWr,
	input  logic memMemRd,
	input  logic memMemWr,
	input  wbSrcT memWbSrc,
	input  logic [`CPU_DATA_W-1:0] memImm,
	input  logic memHalt,
	output logic [`CPU_DATA_W-1:0] wbAluOut,
	output logic [`CPU_DATA_W-1:0] wbMemOut,
	output logic [`CPU_DATA_W-1:0] wbImm,
	output wbSrcT wbSrc,
	output logic [$clog2(`CPU_NREGS)-1:0] wbRd,
	output logic wbRegWr,
	output logic wbHalt
);

	localparam int dmemAw = $clog2(`CPU_DMEM_DEPTH);

	logic [`CPU_DATA_W-1:0] dmem [`CPU_DMEM_DEPTH];
	logic [dmemAw-1:0] addr;

	// Word address, upper bits must be zero
	assign addr = memAluOut[dmemAw-1:0];

	// Synchronous read lands straight in MEM/WB
	always_ff @(posedge clk) begin
		if (memMemWr) begin
			dmem[addr] <= memStoreData;
		end
		if (memMemRd) begin
			wbMemOut <= dmem[addr];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wbRegWr <= 1'b0;
			wbHalt <= 1'b0;
		end else begin
			wbRegWr <= memRegWr;
			wbHalt <= memHalt;
		end
	end

	always_ff @(posedge clk) begin
		wbAluOut <= memAluOut;
		wbImm <= memImm;
		wbSrc <= memWbSrc;
		wbRd <= memRd;
	end

	// Program sets base registers so accesses stay inside the array
	addrInRange: assert property (@(posedge clk) disable iff (rst)
		(memMemRd || memMemWr) |-> memAluOut < `CPU_DMEM_DEPTH);

endmodule

/* src/cpu.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu import cpuPkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic imemWe,
	input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imemAddr,
	input  logic [`CPU_DATA_W-1:0] imemData,
	output logic [`CPU_DATA_W-1:0] pc,
	output logic hlt,
	output logic commitValid,
	output logic [$clog2(`CPU_NREGS)-1:0] commitReg,
	output logic [`CPU_DATA_W-1:0] commitData
);

	// IF/ID and decode feedback
	instrT instrId;
	logic [`CPU_DATA_W-1:0] pcId, branchTarget;
	logic stall, halt, branchTaken;

	// ID/EX
	opcodeT exOp;
	wbSrcT exWbSrc;
	logic [$clog2(`CPU_NREGS)-1:0] exRd, exRs, exRt;
	logic [`CPU_DATA_W-1:0] exData1, exData2, exImm;
	logic exAluSrc, exMemRd, exMemWr, exRegWr, exHalt;
	logic [2:0] flags;

	// EX/MEM
	wbSrcT memWbSrc;
	logic [$clog2(`CPU_NREGS)-1:0] memRd;
	logic [`CPU_DATA_W-1:0] memAluOut, memStoreData, memImm;
	logic memRegWr, memMemRd, memMemWr, memHalt;

	// MEM/WB and writeback
	wbSrcT wbSrc;
	logic [$clog2(`CPU_NREGS)-1:0] wbRd;
	logic [`CPU_DATA_W-1:0] wbAluOut, wbMemOut, wbImm, wbData;
	logic wbRegWr, wbHalt, hltSeen;

	fetch fetch_i (.*);
	decode decode_i (.*);
	execute execute_i (.*);
	memory memory_i (.*);

	// Writeback select, also feeds the bypass and forwarding paths
	always_comb begin
		case (wbSrc)
			MEM: wbData = wbMemOut;
			IMM: wbData = wbImm;
			default: wbData = wbAluOut;
		endcase
	end

	// Sticky halt once HLT retires
	always_ff @(posedge clk) begin
		if (rst) begin
			hltSeen <= 1'b0;
		end else if (wbHalt) begin
			hltSeen <= 1'b1;
		end
	end

	assign hlt = hltSeen | wbHalt;

	// Commit trace, r0 writes dropped
	assign commitValid = wbRegWr && (wbRd != '0) && !hltSeen;
	assign commitReg = wbRd;
	assign commitData = wbData;

endmodule

/* test/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Expected register writes in program order, {reg, data}
logic [19:0] expQ [$];

// pc once fetch has stopped, one word past the HLT
logic [15:0] expPc;

// Branch conditions on N, V, Z
function automatic logic condMet(input logic [2:0] c, input logic n, input logic v,
	input logic z);
	case (condT'(c))
		NE: return !z;
		EQ: return z;
		GT: return !z && !n;
		LT: return n;
		GE: return !n;
		LE: return n || z;
		OVF: return v;
		default: return 1'b1;
	endcase
endfunction

// Architectural run of prog, one instruction at a time
function automatic void cpuModel();
	logic [15:0] rf [16];
	logic [15:0] dm [256];
	logic [15:0] w, a, b, r;
	logic [7:0] addr;
	logic [3:0] rd;
	logic n, v, z, wr;
	int p;
	rf = '{default: '0};
	dm = '{default: '0};
	n = 1'b0;
	v = 1'b0;
	z = 1'b0;
	p = 0;
	expPc = '0;
	expQ.delete();
	while (p < progLen) begin
		w = prog[p];
		rd = w[11:8];
		a = rf[w[7:4]];
		b = rf[w[3:0]];
		addr = 8'(a + {12'h000, w[3:0]});
		r = '0;
		wr = 1'b0;
		// Next sequential word, branches add to it
		p++;
		case (opcodeT'(w[15:12]))
			ADD: begin
				r = a + b;
				v = (a[15] == b[15]) && (r[15] != a[15]);
				wr = 1'b1;
			end
			SUB: begin
				r = a - b;
				v = (a[15] != b[15]) && (r[15] != a[15]);
				wr = 1'b1;
			end
			AND: begin
				r = a & b;
				v = 1'b0;
				wr = 1'b1;
			end
			XOR: begin
				r = a ^ b;
				v = 1'b0;
				wr = 1'b1;
			end
			LLB: begin
				r = {rf[rd][15:8], w[7:0]};
				wr = 1'b1;
			end
			LHB: begin
				r = {w[7:0], rf[rd][7:0]};
				wr = 1'b1;
			end
			LW: begin
				r = dm[addr];
				wr = 1'b1;
			end
			SW: dm[addr] = rf[rd];
			B: begin
				if (condMet(w[11:9], n, v, z)) begin
					p = p + int'($signed(w[8:0]));
				end
			end
			HLT: begin
				// The HLT word was fetched, so pc already moved past it
				expPc = 16'(p);
				return;
			end
			default: ;
		endcase
		// Only the four ALU ops leave N and Z behind
		if (w[15:14] == 2'b00) begin
			n = r[15];
			z = (r == '0);
		end
		if (wr && rd != 4'd0) begin
			rf[rd] = r;
			expQ.push_back({rd, r});
		end
	end
endfunction

`endif

/* test/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

	localparam int clkPeriod = 40;
	localparam int resetCycles = 16;
	localparam int numProgs = 4;
	localparam int progLen = 60;
	// Four cycles per instruction, plus load, reset and drain per program
	localparam int watchdogNs = (4 * numProgs * progLen
		+ numProgs * (progLen + resetCycles + 8)) * clkPeriod;

	logic clk, rst, imemWe;
	logic [7:0] imemAddr;
	logic [15:0] imemData, pc, commitData;
	logic hlt, commitValid;
	logic [3:0] commitReg;

	logic [15:0] prog [progLen];
	logic [31:0] lfsr = 32'h6c55;
	int errors = 0;
	int commits = 0;
	logic haltSeen;

	`include "cpuModel.svh"

	cpu cpu_i (.*);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Galois right shift, feedback mask 0x80200003
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] randBits(input int cnt);
		logic [31:0] bits;
		bits = '0;
		for (int k = 0; k < cnt; k++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
		return bits;
	endfunction

	task automatic genProgram();
		logic [2:0] kind, rd, ra, rb;
		logic [1:0] sel;
		logic [7:0] imm;
		// r13 holds the data base, offsets 0 to 3 stay in range
		prog[0] = {LLB, 4'd13, 4'(randBits(4)), 4'h0};
		prog[1] = {LHB, 4'd13, 8'h00};
		// Define every word that a later LW can read
		for (int k = 0; k < 4; k++) begin
			prog[2 + k] = {SW, 4'd13, 4'd13, 4'(k)};
		end
		for (int k = 6; k < progLen - 1; k++) begin
			kind = 3'(randBits(3));
			rd = 3'(randBits(3));
			ra = 3'(randBits(3));
			rb = 3'(randBits(3));
			sel = 2'(randBits(2));
			imm = 8'(randBits(8));
			case (kind)
				3'd3: prog[k] = {LLB, 1'b0, rd, imm};
				3'd4: prog[k] = {LHB, 1'b0, rd, imm};
				3'd5: prog[k] = {LW, 1'b0, rd, 4'd13, 2'b00, sel};
				3'd6: prog[k] = {SW, 1'b0, rd, 4'd13, 2'b00, sel};
				// Forward only, never past HLT
				3'd7: prog[k] = (k <= progLen - 5) ? {B, rd, 1'b0, 6'h00, sel}
					: {XOR, 1'b0, rd, 1'b0, ra, 1'b0, rb};
				// Codes 0 to 3 are the ALU ops
				default: prog[k] = {2'b00, sel, 1'b0, rd, 1'b0, ra, 1'b0, rb};
			endcase
		end
		prog[progLen - 1] = {HLT, 12'h000};
	endtask

	task automatic runProgram();
		@(posedge clk);
		rst <= 1'b1;
		// Load port only while in reset
		for (int k = 0; k < progLen; k++) begin
			@(posedge clk);
			imemWe <= 1'b1;
			imemAddr <= 8'(k);
			imemData <= prog[k];
		end
		@(posedge clk);
		imemWe <= 1'b0;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
		// Watchdog bounds this wait
		@(negedge clk);
		while (hlt !== 1'b1) @(negedge clk);
		repeat (4) @(negedge clk);
		if (expQ.size() != 0) begin
			$display("Program ended with %0d expected commits missing", expQ.size());
			errors++;
		end
		// Fetch stays frozen just past the HLT
		if (pc !== expPc) begin
			$display("FAILED pc: got %h, expected %h", pc, expPc);
			errors++;
		end
	endtask

	initial begin
		rst = 1'b1;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		for (int p = 0; p < numProgs; p++) begin
			genProgram();
			cpuModel();
			runProgram();
		end
		$display("Programs %0d, commits %0d, errors %0d", numProgs, commits, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Commit checker, mid-cycle so outputs are settled
	always @(negedge clk) begin
		logic [19:0] want;
		if (rst) begin
			haltSeen = 1'b0;
		end else begin
			if (commitValid === 1'b1) begin
				commits++;
				if (haltSeen) begin
					$display("Commit to r%0d after hlt rose", commitReg);
					errors++;
				end
				if (expQ.size() == 0) begin
					$display("Unexpected commit to r%0d, data %h", commitReg, commitData);
					errors++;
				end else begin
					want = expQ.pop_front();
					if (commitReg !== want[19:16]) begin
						$display("FAILED commitReg: got %h, expected %h", commitReg, want[19:16]);
						errors++;
					end
					if (commitData !== want[15:0]) begin
						$display("FAILED commitData: got %h, expected %h", commitData, want[15:0]);
						errors++;
					end
				end
			end else if (commitValid !== 1'b0) begin
				$display("commitValid is unknown at %0t", $time);
				errors++;
			end
			// First cycle of hlt, every write must be in
			if (hlt === 1'b1 && !haltSeen) begin
				haltSeen = 1'b1;
				if (expQ.size() != 0) begin
					$display("hlt rose with %0d commits still expected", expQ.size());
					errors++;
				end
			end
		end
	end

	initial begin
		#(watchdogNs);
		$display("Watchdog expired at %0t before the last program halted", $time);
		$display("Programs %0d, commits %0d, errors %0d", numProgs, commits, errors);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* cpu.f */
+incdir+src
+incdir+test
src/cpuPkg.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/memory.sv
src/cpu.sv
test/cpuTb.sv

/* Makefile */
# Verilator flow for the cpu core and its testbench

VERILATOR ?= verilator
TOP ?= cpuTb
RTL_TOP ?= cpu
FILELIST ?= cpu.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 4
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

# Lint the synthesizable top only
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build, run, then judge the run from its log
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
